//--- bench/nabp_stimulus.txt
# records: P sh_base mp_init mp_base | S sample0..sample15 | C command arg | X pixel0..pixel7
# values in hex; status arg is {next_itr, swap_ready, pe_en}, wait arg is a status bit mask
C status 4
X 0 0 0 0 0 0 0 0
# swap with nothing filled
C swap 0
C status 4
X 0 0 0 0 0 0 0 0
# first angle
P 3 18 28
S 011 022 033 044 055 066 077 088 099 0aa 0bb 0cc 0dd 0ee 0ff 110
C start 0
C wait 2
C status 2
# second angle loaded while the first line waits in the shifter
P 5 34 1c
S 200 201 202 203 204 205 206 207 208 209 20a 20b 20c 20d 20e 20f
C swap 0
C wait 4
X 0022 0088 00dd 0033 0088 00ee 0033 0099
C start 0
C wait 2
# third angle is a negative line
P e f0 10
S ff0 fef fee fed fec feb fea fe9 fe8 fe7 fe6 fe5 fe4 fe3 fe2 fe1
C swap 0
# start lands during the shift and waits
C start 0
C status 1
C wait 2
X 0225 0292 02dd 023a 0296 02f3 023e 029b
C clear 0
X 0 0 0 0 0 0 0 0
C swap 0
C wait 4
X ffe1 ffe2 ffe3 ffe4 ffe5 ffe6 ffe7 ffe8
C status 4

//--- nabp_top.f
verilog/nabp_pkg.sv
verilog/nabp_swap_control.sv
verilog/nabp_state_control.sv
verilog/nabp_shifter.sv
verilog/nabp_mapper.sv
verilog/nabp_pe_array.sv
verilog/nabp_top.sv
bench/nabp_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= nabp_tb
RTL_TOP   ?= nabp_top
FILELIST  ?= nabp_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
RTL_SRCS  ?= verilog/nabp_pkg.sv verilog/nabp_swap_control.sv verilog/nabp_state_control.sv \
             verilog/nabp_shifter.sv verilog/nabp_mapper.sv verilog/nabp_pe_array.sv \
             verilog/nabp_top.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/nabp_tb.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_tb
    import nabp_pkg::*;
;

    localparam int bus_timeout = 16;
    localparam int status_polls = 200;

    logic clk;
    logic reset_n;
    wb_m2s_t wb_in;
    wb_s2m_t wb_out;

    int fd;
    logic [127:0] tag;
    logic [8*128-1:0] rest;

    nabp_top dut (
        .clk(clk),
        .reset_n(reset_n),
        .wb_in(wb_in),
        .wb_out(wb_out)
    );

    always
    begin
        #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic bad_record(input string kind);
        $display("stimulus file has a malformed or unknown %s record", kind);
        abort_run();
    endtask

    // one classic cycle, strobe held through the cycle after ack
    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge clk);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        n = 1;
        while (!wb_out.ack)
        begin
            if (n >= bus_timeout)
            begin
                $display("timeout waiting for Wishbone ack at address %h", adr);
                abort_run();
            end
            n++;
            @(negedge clk);
        end
        rdat = wb_out.dat;
        @(negedge clk);
        wb_in = '0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdat);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, wdat, unused_rd);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, 32'h0, rdat);
    endtask

    // poll the status word until any bit of mask shows up
    task automatic wait_status(input logic [2:0] mask);
        logic [31:0] rd;
        int polls;
        polls = 0;
        wb_read(reg_ctrl, rd);
        while ((rd[2:0] & mask) == 3'b000)
        begin
            if (polls >= status_polls)
            begin
                $display("timeout waiting for status bits %b to be set", mask);
                abort_run();
            end
            polls++;
            wb_read(reg_ctrl, rd);
        end
    endtask

    task automatic check_status(input nabp_status_t got, input nabp_status_t exp);
        if (got !== exp)
        begin
            $display({"ERROR at %0d ns: status next_itr/swap_ready/pe_en ",
                      "read %b%b%b, expected %b%b%b"},
                     $time, got.next_itr, got.swap_ready, got.pe_en,
                     exp.next_itr, exp.swap_ready, exp.pe_en);
            abort_run();
        end
    endtask

    task automatic check_pixel(input int idx, input pix_acc_t got, input pix_acc_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0d ns: pixel %0d read %0d (%h), expected %0d (%h)",
                     $time, idx, got, got, exp, exp);
            abort_run();
        end
    endtask

    task automatic apply_params();
        logic [31:0] sh;
        logic [31:0] init;
        logic [31:0] base;
        if ($fscanf(fd, "%h %h %h", sh, init, base) != 3)
            bad_record("P");
        wb_write(reg_sh_base, {28'h0, sh[3:0]});
        wb_write(reg_mp_init, {24'h0, init[7:0]});
        wb_write(reg_mp_base, {24'h0, base[7:0]});
    endtask

    task automatic load_samples();
        logic [31:0] v;
        for (int i = 0; i < n_samp; i++)
        begin
            if ($fscanf(fd, "%h", v) != 1)
                bad_record("S");
            wb_write(8'(reg_samp_base) + 8'(i), {20'h0, v[11:0]});
        end
    endtask

    task automatic check_pixels();
        logic [31:0] v;
        logic [31:0] rd;
        for (int i = 0; i < n_pix; i++)
        begin
            if ($fscanf(fd, "%h", v) != 1)
                bad_record("X");
            wb_read(8'(reg_pix_base) + 8'(i), rd);
            check_pixel(i, pix_acc_t'(rd[15:0]), pix_acc_t'(v[15:0]));
        end
    endtask

    task automatic run_command();
        logic [127:0] cmd;
        logic [31:0] arg;
        logic [31:0] rd;
        if ($fscanf(fd, "%s %h", cmd, arg) != 2)
            bad_record("C");
        case (cmd)
            128'("start"): wb_write(reg_ctrl, 32'(1 << ctrl_start_bit));
            128'("swap"):  wb_write(reg_ctrl, 32'(1 << ctrl_swap_bit));
            128'("clear"): wb_write(reg_ctrl, 32'(1 << ctrl_clear_bit));
            128'("wait"):  wait_status(arg[2:0]);
            128'("status"):
            begin
                wb_read(reg_ctrl, rd);
                check_status(nabp_status_t'(rd[2:0]), nabp_status_t'(arg[2:0]));
            end
            default: bad_record("C");
        endcase
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        wb_in = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        fd = $fopen("bench/nabp_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/nabp_stimulus.txt");
            abort_run();
        end

        // one record per line, tag first
        while ($fscanf(fd, "%s", tag) == 1)
        begin
            case (tag)
                128'("#"): void'($fgets(rest, fd));
                128'("P"): apply_params();
                128'("S"): load_samples();
                128'("C"): run_command();
                128'("X"): check_pixels();
                default:   bad_record("tagged");
            endcase
        end
        $fclose(fd);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/nabp_top.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_top
    import nabp_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire wb_m2s_t wb_in,
    output wb_s2m_t wb_out
);

    nabp_param_t sw_param;
    logic sw_next_itr_ack;
    logic sw_swap;
    logic clear;
    logic sw_next_itr;
    logic sw_swap_ready;
    logic sw_pe_en;
    logic sh_fill_kick;
    logic sh_shift_kick;
    logic [3:0] sh_accu_base;
    logic [7:0] mp_accu_init;
    logic [7:0] mp_accu_base;
    logic sh_fill_done;
    logic sh_shift_done;
    samp_idx_t fill_idx;
    sample_t fill_data;
    line_t line;
    samp_idx_t map_idx;
    pix_acc_t [n_pix-1:0] pix;

    nabp_swap_control u_swap_control (
        .clk(clk), .reset_n(reset_n), .wb_in(wb_in), .wb_out(wb_out), .pix(pix),
        .sw_next_itr(sw_next_itr), .sw_swap_ready(sw_swap_ready), .sw_pe_en(sw_pe_en),
        .sw_param(sw_param), .sw_next_itr_ack(sw_next_itr_ack), .sw_swap(sw_swap),
        .clear(clear), .fill_idx(fill_idx), .fill_data(fill_data)
    );

    nabp_state_control u_state_control (
        .clk(clk), .reset_n(reset_n), .sw_param(sw_param),
        .sw_next_itr_ack(sw_next_itr_ack), .sw_swap(sw_swap),
        .sh_fill_done(sh_fill_done), .sh_shift_done(sh_shift_done),
        .sw_swap_ready(sw_swap_ready), .sw_next_itr(sw_next_itr), .sw_pe_en(sw_pe_en),
        .sh_fill_kick(sh_fill_kick), .sh_shift_kick(sh_shift_kick),
        .sh_accu_base(sh_accu_base), .mp_accu_init(mp_accu_init),
        .mp_accu_base(mp_accu_base)
    );

    nabp_shifter u_shifter (
        .clk(clk), .reset_n(reset_n), .sh_fill_kick(sh_fill_kick),
        .sh_shift_kick(sh_shift_kick), .sh_accu_base(sh_accu_base),
        .fill_data(fill_data), .fill_idx(fill_idx), .sh_fill_done(sh_fill_done),
        .sh_shift_done(sh_shift_done), .line(line)
    );

    nabp_mapper u_mapper (
        .clk(clk), .reset_n(reset_n), .sh_shift_kick(sh_shift_kick),
        .mp_accu_init(mp_accu_init), .mp_accu_base(mp_accu_base), .map_idx(map_idx)
    );

    nabp_pe_array u_pe_array (
        .clk(clk), .reset_n(reset_n), .pe_en(sw_pe_en), .clear(clear),
        .line(line), .map_idx(map_idx), .pix(pix)
    );

endmodule

`default_nettype wire

//--- verilog/nabp_pe_array.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_pe_array
    import nabp_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic pe_en,
    input  wire logic clear,
    input  wire line_t line,
    input  wire samp_idx_t map_idx,
    output pix_acc_t [n_pix-1:0] pix
);

    pix_acc_t [n_pix-1:0] acc;
    logic [$clog2(n_pix)-1:0] k;
    sample_t sel;

    assign sel = line[map_idx];

    // step counter picks the pixel, restarts each iteration
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            k <= '0;
        else if (pe_en)
            k <= k + 1'b1;
        else
            k <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
            acc <= '0;
        else if (pe_en)
            acc[k] <= acc[k] + pix_acc_t'(sel);
    end

    assign pix = acc;

endmodule

`default_nettype wire

//--- verilog/nabp_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_mapper
    import nabp_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic sh_shift_kick,
    input  wire logic [7:0] mp_accu_init,
    input  wire logic [7:0] mp_accu_base,
    output samp_idx_t map_idx
);

    // Q4.4 position, wraps at 16 samples
    logic [7:0] accu;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            accu <= '0;
        else if (sh_shift_kick)
            accu <= mp_accu_init;
        else
            accu <= accu + mp_accu_base;
    end

    // integer part only
    assign map_idx = accu[7:4];

endmodule

`default_nettype wire

//--- verilog/nabp_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_shifter
    import nabp_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic sh_fill_kick,
    input  wire logic sh_shift_kick,
    input  wire logic [3:0] sh_accu_base,
    input  wire sample_t fill_data,
    output samp_idx_t fill_idx,
    output logic sh_fill_done,
    output logic sh_shift_done,
    output line_t line
);

    line_t line_q;
    line_t line_rot;
    samp_idx_t cnt;
    logic filling;
    logic shifting;

    // left rotation, element j takes sample j + step
    always_comb
    begin
        for (int j = 0; j < n_samp; j++)
        begin
            line_rot[j] = line_q[samp_idx_t'(j) + sh_accu_base];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filling <= 1'b0;
            shifting <= 1'b0;
            cnt <= '0;
        end
        else if (sh_fill_kick)
        begin
            filling <= 1'b1;
            cnt <= '0;
        end
        else if (sh_shift_kick)
        begin
            shifting <= 1'b1;
            cnt <= '0;
        end
        else if (filling)
        begin
            cnt <= cnt + 1'b1;
            if (sh_fill_done)
                filling <= 1'b0;
        end
        else if (shifting)
        begin
            cnt <= cnt + 1'b1;
            if (sh_shift_done)
                shifting <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (filling)
            line_q[cnt] <= fill_data;
        else if (shifting)
            line_q <= line_rot;
    end

    assign fill_idx = cnt;
    assign sh_fill_done = filling && (cnt == samp_idx_t'(n_samp - 1));
    assign sh_shift_done = shifting && (cnt == samp_idx_t'(n_pix - 1));
    assign line = line_q;

    // done lands exactly one full line after the kick
    a_fill_done_count: assert property (@(posedge clk) disable iff (!reset_n)
        sh_fill_done |-> $past(sh_fill_kick, n_samp));

endmodule

`default_nettype wire

//--- verilog/nabp_state_control.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_state_control
    import nabp_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire nabp_param_t sw_param,
    input  wire logic sw_next_itr_ack,
    input  wire logic sw_swap,
    input  wire logic sh_fill_done,
    input  wire logic sh_shift_done,
    output logic sw_swap_ready,
    output logic sw_next_itr,
    output logic sw_pe_en,
    output logic sh_fill_kick,
    output logic sh_shift_kick,
    output logic [3:0] sh_accu_base,
    output logic [7:0] mp_accu_init,
    output logic [7:0] mp_accu_base
);

    nabp_state_e state;
    nabp_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    // parameters only move while idle, so a running iteration keeps its own
    always_ff @(posedge clk)
    begin
        if (state == ready_s)
        begin
            sh_accu_base <= sw_param.sh_accu_base;
            mp_accu_init <= sw_param.mp_accu_init;
            mp_accu_base <= sw_param.mp_accu_base;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:     if (sw_next_itr_ack) next_state = fill_s;
            fill_s:      if (sh_fill_done) next_state = fill_done_s;
            fill_done_s: if (sw_swap) next_state = shift_s;
            shift_s:     if (sh_shift_done) next_state = ready_s;
            default:     next_state = ready_s;
        endcase
    end

    assign sw_next_itr = (state == ready_s);
    assign sw_swap_ready = (state == fill_done_s);
    assign sw_pe_en = (state == shift_s);
    // kicks fire in the cycle before the phase begins
    assign sh_fill_kick = (next_state != state) && (next_state == fill_s);
    assign sh_shift_kick = (next_state != state) && (next_state == shift_s);

    // shifter done pulses only arrive in their own phase
    a_fill_done_in_fill: assert property (@(posedge clk) disable iff (!reset_n)
        sh_fill_done |-> (state == fill_s));

    a_shift_done_in_shift: assert property (@(posedge clk) disable iff (!reset_n)
        sh_shift_done |-> (state == shift_s));

endmodule

`default_nettype wire

//--- verilog/nabp_swap_control.sv
`timescale 1ns/10ps
`default_nettype none

module nabp_swap_control
    import nabp_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire wb_m2s_t wb_in,
    output wb_s2m_t wb_out,
    input  wire pix_acc_t [n_pix-1:0] pix,
    input  wire logic sw_next_itr,
    input  wire logic sw_swap_ready,
    input  wire logic sw_pe_en,
    output nabp_param_t sw_param,
    output logic sw_next_itr_ack,
    output logic sw_swap,
    output logic clear,
    input  wire samp_idx_t fill_idx,
    output sample_t fill_data
);

    sample_t mem [n_samp];
    nabp_param_t param_q;
    nabp_status_t status;
    logic ack_q;
    logic [31:0] rdat_d;
    logic [31:0] rdat_q;
    logic access;
    logic wr_en;
    logic wr_ctrl;
    logic samp_hit;
    logic pix_hit;
    logic start_pend;

    // one access per cycle pair, ack drops while stb is still high
    assign access = wb_in.cyc && wb_in.stb && !ack_q;
    assign wr_en = access && wb_in.we;
    assign wr_ctrl = wr_en && (wb_in.adr == reg_ctrl);
    assign samp_hit = (wb_in.adr & samp_adr_mask) == reg_samp_base;
    assign pix_hit = (wb_in.adr & pix_adr_mask) == reg_pix_base;

    assign status = '{next_itr: sw_next_itr, swap_ready: sw_swap_ready, pe_en: sw_pe_en};

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ack_q <= 1'b0;
            param_q <= '0;
            start_pend <= 1'b0;
            sw_next_itr_ack <= 1'b0;
            sw_swap <= 1'b0;
            clear <= 1'b0;
        end
        else
        begin
            ack_q <= access;
            if (wr_en)
            begin
                case (wb_in.adr)
                    reg_sh_base: param_q.sh_accu_base <= wb_in.dat[3:0];
                    reg_mp_init: param_q.mp_accu_init <= wb_in.dat[7:0];
                    reg_mp_base: param_q.mp_accu_base <= wb_in.dat[7:0];
                    default: ;
                endcase
            end
            // start waits here until the state machine is ready
            if (wr_ctrl && wb_in.dat[ctrl_start_bit])
                start_pend <= 1'b1;
            else if (sw_next_itr_ack)
                start_pend <= 1'b0;
            sw_next_itr_ack <= start_pend && sw_next_itr && !sw_next_itr_ack;
            // swap only counts once the line has been copied
            sw_swap <= wr_ctrl && wb_in.dat[ctrl_swap_bit] && sw_swap_ready;
            clear <= wr_ctrl && wb_in.dat[ctrl_clear_bit];
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en && samp_hit)
            mem[wb_in.adr[3:0]] <= sample_t'(wb_in.dat[11:0]);
        if (access)
            rdat_q <= rdat_d;
    end

    always_comb
    begin
        rdat_d = '0;
        if (samp_hit)
            rdat_d = 32'(mem[wb_in.adr[3:0]]);
        else if (pix_hit)
            rdat_d = 32'(pix[wb_in.adr[2:0]]);
        else
        begin
            case (wb_in.adr)
                reg_ctrl:    rdat_d = 32'(status);
                reg_sh_base: rdat_d = 32'(param_q.sh_accu_base);
                reg_mp_init: rdat_d = 32'(param_q.mp_accu_init);
                reg_mp_base: rdat_d = 32'(param_q.mp_accu_base);
                default:     rdat_d = '0;
            endcase
        end
    end

    assign wb_out = '{ack: ack_q, dat: rdat_q};
    assign sw_param = param_q;
    // fill reads the memory directly
    assign fill_data = mem[fill_idx];

    // host must hold the strobe until it sees ack
    a_ack_with_stb: assert property (@(posedge clk) disable iff (!reset_n)
        ack_q |-> (wb_in.cyc && wb_in.stb));

endmodule

`default_nettype wire

//--- verilog/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // line and row sizes
    localparam int n_samp = 16;
    localparam int n_pix = 8;

    // command bits in a reg_ctrl write
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_swap_bit = 1;
    localparam int ctrl_clear_bit = 2;

    // address masks for the sample and pixel windows
    localparam logic [7:0] samp_adr_mask = 8'hf0;
    localparam logic [7:0] pix_adr_mask = 8'hf8;

    typedef logic signed [11:0] sample_t;
    typedef sample_t [n_samp-1:0] line_t;
    typedef logic [3:0] samp_idx_t;
    typedef logic signed [15:0] pix_acc_t;

    typedef struct packed {
        logic [3:0] sh_accu_base;
        // Q4.4 values
        logic [7:0] mp_accu_init;
        logic [7:0] mp_accu_base;
    } nabp_param_t;

    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s
    } nabp_state_e;

    // word addresses on the host bus
    typedef enum logic [7:0] {
        reg_ctrl      = 8'h00,
        reg_sh_base   = 8'h01,
        reg_mp_init   = 8'h02,
        reg_mp_base   = 8'h03,
        reg_samp_base = 8'h10,
        reg_pix_base  = 8'h20
    } nabp_reg_e;

    typedef struct packed {
        logic next_itr;
        logic swap_ready;
        logic pe_en;
    } nabp_status_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [7:0] adr;
        logic [31:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic ack;
        logic [31:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire
